// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_mem_tile
RTL_TOP    := mem_tile
FILELIST   := filelist.f
PASS_MSG   := Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
verilog/tile_pkg.sv
verilog/mem_bus_if.sv
verilog/tile_addr_demux.sv
verilog/l1_spm.sv
verilog/l2_bridge.sv
verilog/mem_tile.sv
verif/tb_clk_gen.sv
verif/tb_mem_tile.sv

// ==== verif/tb_clk_gen.sv ====
// ************************************************
// Testbench clock and reset
// 10 ns clock, reset low for the first 5 cycles
// ************************************************

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin : clk_loop
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;   // 10 ns period
  end

  initial begin : rst_seq
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_no = 1'b1;   // Released off the edge like all stimulus
  end

endmodule

// ==== verif/tb_mem_tile.sv ====
// ************************************************
// Memory tile testbench
// Drives the host port, models the L2 slave and L1,
// checks the response rules with assertions
// ************************************************

`timescale 1ns/100ps

module tb_mem_tile;
  import tile_pkg::*;

  localparam int unsigned N_WORDS  = 64;   // L1 words under test across rows and banks
  localparam int unsigned N_PART   = 48;   // Random byte-select writes
  localparam int unsigned N_ERR    = 8;
  localparam int unsigned N_L2     = 40;
  localparam int unsigned N_HELD   = 3;    // Accesses made while disabled
  localparam int unsigned MAX_CYC  = 20;   // Worst case cycles for one access
  localparam int unsigned TIMEOUT_CYC =
    (2 * N_WORDS + N_PART + N_ERR + N_L2 + N_HELD) * MAX_CYC;

  logic              clk_i, rst_ni, tile_enable_i;
  logic              wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o, wb_err_o;
  logic [ADDR_W-1:0] wb_adr_i, l2_adr_o;
  logic [DATA_W-1:0] wb_dat_i, wb_dat_o, l2_dat_o, l2_dat_i;
  logic [SEL_W-1:0]  wb_sel_i, l2_sel_o;
  logic              l2_cyc_o, l2_stb_o, l2_we_o, l2_ack_i;

  logic [31:0]       lfsr_q   = 32'h82be3f77;
  int unsigned       errors   = 0;
  int unsigned       n_access = 0;
  int unsigned       cycles   = 0;
  int unsigned       l2_wait;
  logic              en_ref;               // Model of the registered tile enable
  logic              go;                   // Host request the tile may see
  logic              rd_chk   = 1'b0;      // Current access is an L1 read to compare
  logic [DATA_W-1:0] rd_exp   = '0;
  logic [DATA_W-1:0] l2_rdata_q = '0;      // Last data returned by the L2 model
  logic [DATA_W-1:0] ref_mem [N_WORDS];    // L1 reference

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  mem_tile dut (.*);

  // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Expected target from the address map
  function automatic tgt_sel_e tgt_of(input logic [ADDR_W-1:0] adr);
    if (adr >= L1_BASE && adr < L1_BASE + ADDR_W'(N_BANKS * WORDS_PER_BANK * SEL_W)) begin
      return TGT_L1;
    end
    if (adr >= L2_BASE && adr <= L2_END) return TGT_L2;
    return TGT_NONE;
  endfunction

  // Word w lands in bank w[1:0] with its row spread over all row bits
  function automatic logic [ADDR_W-1:0] l1_addr(input int unsigned w);
    return L1_BASE + ADDR_W'({w[5:2], w[3:2], w[1:0], 2'b00});
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("FAILED t=%0t: %s", $time, msg);
  endtask

  // One Wishbone classic access held until ack or err
  task automatic access(input logic we, input logic [ADDR_W-1:0] adr,
                        input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                        input logic chk, input logic [DATA_W-1:0] exp);
    @(posedge clk_i);
    #1;
    rd_chk   = chk;
    rd_exp   = exp;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    @(posedge clk_i);
    #1;
    while (!wb_ack_o && !wb_err_o) begin
      @(posedge clk_i);
      #1;
    end
    wb_cyc_i = 1'b0;   // Address stays so the response mux keeps its target
    wb_stb_i = 1'b0;
    n_access++;
  endtask

  // Access issued while the tile is disabled and enabled six cycles later
  task automatic access_while_disabled(input logic [ADDR_W-1:0] adr, input logic chk,
                                       input logic [DATA_W-1:0] exp);
    @(posedge clk_i);
    #1;
    tile_enable_i = 1'b0;
    fork
      access(1'b0, adr, '0, '0, chk, exp);
      begin
        repeat (6) @(posedge clk_i);
        #1;
        tile_enable_i = 1'b1;
      end
    join
  endtask

  always_ff @(posedge clk_i, negedge rst_ni) begin : enable_model
    if (!rst_ni) en_ref <= 1'b0;
    else         en_ref <= tile_enable_i;
  end

  assign go = wb_cyc_i & wb_stb_i & en_ref;

  a_l1_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(go) && tgt_of(wb_adr_i) == TGT_L1 |=> wb_ack_o)
    else report_fail("L1 ack missing one cycle after stb");
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o) else report_fail("wb_ack_o longer than one cycle");
  a_rd_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o && rd_chk |-> wb_dat_o == rd_exp)
    else report_fail($sformatf("L1 read data wrong, expected %h", rd_exp));
  a_l2_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(go) && tgt_of(wb_adr_i) == TGT_L2 |=> l2_cyc_o)
    else report_fail("l2_cyc_o not raised one cycle after stb");
  a_l2_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_cyc_o |-> l2_stb_o && tgt_of(wb_adr_i) == TGT_L2 && l2_adr_o == wb_adr_i &&
                 l2_we_o == wb_we_i && l2_sel_o == wb_sel_i &&
                 (!wb_we_i || l2_dat_o == wb_dat_i))
    else report_fail("L2 request fields differ from host access");
  a_l2_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_cyc_o && !l2_ack_i |=> l2_cyc_o) else report_fail("l2_cyc_o dropped before ack");
  a_l2_ret: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_cyc_o && l2_ack_i |=> wb_ack_o && (l2_we_o || wb_dat_o == l2_rdata_q))
    else report_fail("L2 response not returned one cycle after l2_ack_i");
  a_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(go) && tgt_of(wb_adr_i) == TGT_NONE |=> wb_err_o)
    else report_fail("wb_err_o missing for unmapped address");
  a_err_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_err_o |=> !wb_err_o) else report_fail("wb_err_o longer than one cycle");
  a_err_no_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (go && tgt_of(wb_adr_i) == TGT_NONE) || wb_err_o |-> !wb_ack_o)
    else report_fail("wb_ack_o on an unmapped access");
  a_disabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_ref |-> !wb_ack_o && !wb_err_o && !l2_cyc_o)
    else report_fail("Response seen while the tile is disabled");

  // L2 slave answers after 0 to 7 cycles
  always begin : l2_slave
    @(posedge clk_i);
    #1;
    if (l2_cyc_o) begin
      l2_wait = rand_bits(3);
      repeat (l2_wait) begin
        @(posedge clk_i);
        #1;
      end
      l2_rdata_q = rand_bits(DATA_W);
      l2_dat_i   = l2_rdata_q;
      l2_ack_i   = 1'b1;
      @(posedge clk_i);
      #1;
      l2_ack_i   = 1'b0;
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Run timed out after %0d cycles with an access still open", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    logic [5:0]        w;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic [SEL_W-1:0]  s;
    tile_enable_i = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    wb_sel_i      = '0;
    l2_dat_i      = '0;
    l2_ack_i      = 1'b0;
    wait (rst_ni);
    tile_enable_i = 1'b1;
    for (int unsigned i = 0; i < N_WORDS; i++) begin   // Full-word fill
      d          = rand_bits(DATA_W);
      ref_mem[i] = d;
      access(1'b1, l1_addr(i), d, '1, 1'b0, '0);
    end
    repeat (N_PART) begin
      w = 6'(rand_bits(6));
      d = rand_bits(DATA_W);
      s = SEL_W'(rand_bits(SEL_W));
      for (int b = 0; b < SEL_W; b++) begin
        if (s[b]) ref_mem[w][8*b +: 8] = d[8*b +: 8];   // Byte lane merge
      end
      access(1'b1, l1_addr(w), d, s, 1'b0, '0);
    end
    for (int unsigned i = 0; i < N_ERR; i++) begin   // Unmapped writes leave L1 unchanged
      case (i % 4)
        0:       a = l1_addr(rand_bits(6)) + 32'h400;   // Aliases a tested word
        1:       a = L1_BASE - 32'd4;
        2:       a = 32'h9000_0000 | rand_bits(28);
        default: a = 32'h7FFF_FFFC;
      endcase
      d = rand_bits(DATA_W);
      access(1'b1, a, d, '1, 1'b0, '0);
    end
    repeat (N_L2) begin
      w = 6'(rand_bits(1));
      a = L2_BASE | (rand_bits(26) << 2);
      d = rand_bits(DATA_W);
      s = SEL_W'(rand_bits(SEL_W));
      access(w[0], a, d, s, 1'b0, '0);
    end
    access_while_disabled(l1_addr(3), 1'b1, ref_mem[3]);
    access_while_disabled(L2_BASE + 32'h100, 1'b0, '0);
    access_while_disabled(32'h0000_0040, 1'b0, '0);
    for (int unsigned i = 0; i < N_WORDS; i++) begin   // Readback across all banks
      access(1'b0, l1_addr(i), '0, '0, 1'b1, ref_mem[i]);
    end
    repeat (2) @(posedge clk_i);
    $display("Accesses: %0d, errors: %0d", n_access, errors);
    if (errors == 0) $display("Simulation finished: PASS");
    else             $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== verilog/l1_spm.sv ====
// ************************************************
// L1 scratchpad
// Word-interleaved banks with byte-select writes,
// single cycle registered response
// ************************************************

`timescale 1ns/100ps

module l1_spm (
  input  logic       clk_i,
  input  logic       rst_ni,
  mem_bus_if.target  bus_i
);
  import tile_pkg::*;

  logic                  access;    // New access this cycle
  logic                  ack_q;
  logic [BANK_IDX_W-1:0] bank_idx;
  logic [BANK_IDX_W-1:0] bank_q;    // Bank of the pending read
  logic [ROW_IDX_W-1:0]  row_idx;
  logic [DATA_W-1:0]     bank_rdata [N_BANKS];

  // Ack cycle blocks a second access while stb is still high
  assign access   = bus_i.cyc & bus_i.stb & ~ack_q;
  assign bank_idx = bus_i.adr[BANK_IDX_W+1:2];                         // Word interleave
  assign row_idx  = bus_i.adr[ROW_IDX_W+BANK_IDX_W+1:BANK_IDX_W+2];

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem_q [WORDS_PER_BANK];
    logic [DATA_W-1:0] rdata_q;
    logic              bank_req;

    assign bank_req = access & (bank_idx == BANK_IDX_W'(b));

    always_ff @(posedge clk_i) begin : bank_rw
      if (bank_req) begin
        if (bus_i.we) begin
          for (int unsigned i = 0; i < SEL_W; i++) begin
            if (bus_i.sel[i]) begin
              mem_q[row_idx][8*i +: 8] <= bus_i.dat_w[8*i +: 8];   // Selected lanes only
            end
          end
        end
        rdata_q <= mem_q[row_idx];   // Full word, old value on write
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin : ack_ff
    if (!rst_ni) ack_q <= 1'b0;
    else         ack_q <= access;
  end

  always_ff @(posedge clk_i) begin : bank_sel_ff
    if (access) bank_q <= bank_idx;
  end

  assign bus_i.dat_r = bank_rdata[bank_q];
  assign bus_i.ack   = ack_q;

endmodule

// ==== verilog/l2_bridge.sv ====
// ************************************************
// L2 bridge
// Registers accesses onto the external L2 bus and
// returns the response after a variable wait
// ************************************************

`timescale 1ns/100ps

module l2_bridge (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  mem_bus_if.target                   bus_i,

  output logic                        l2_cyc_o,
  output logic                        l2_stb_o,
  output logic                        l2_we_o,
  output logic [tile_pkg::ADDR_W-1:0] l2_adr_o,
  output logic [tile_pkg::DATA_W-1:0] l2_dat_o,
  output logic [tile_pkg::SEL_W-1:0]  l2_sel_o,
  input  logic [tile_pkg::DATA_W-1:0] l2_dat_i,
  input  logic                        l2_ack_i
);
  import tile_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_WAIT    // Request out on L2, waiting for ack
  } state_e;

  state_e            state_q;
  logic              start;
  logic              ack_q;
  logic [DATA_W-1:0] dat_r_q;

  // No restart in the ack cycle, the host still holds stb then
  assign start = (state_q == ST_IDLE) & bus_i.cyc & bus_i.stb & ~ack_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin : fsm_ff
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;   // Pulse
      case (state_q)
        ST_IDLE: if (start) state_q <= ST_WAIT;
        ST_WAIT: begin
          if (l2_ack_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin : payload_ff
    if (start) begin
      l2_we_o  <= bus_i.we;
      l2_adr_o <= bus_i.adr;
      l2_dat_o <= bus_i.dat_w;
      l2_sel_o <= bus_i.sel;
    end
    if ((state_q == ST_WAIT) && l2_ack_i) dat_r_q <= l2_dat_i;   // Capture at ack
  end

  assign l2_cyc_o    = (state_q == ST_WAIT);
  assign l2_stb_o    = (state_q == ST_WAIT);   // Classic cycle, stb follows cyc
  assign bus_i.dat_r = dat_r_q;
  assign bus_i.ack   = ack_q;

endmodule

// ==== verilog/mem_bus_if.sv ====
// ************************************************
// Memory bus interface
// Wishbone classic link between demux and targets
// ************************************************

`timescale 1ns/100ps

interface mem_bus_if;
  import tile_pkg::*;

  logic              cyc;    // Bus cycle active
  logic              stb;    // Strobe, held until ack
  logic              we;     // Write enable
  logic [ADDR_W-1:0] adr;    // Byte address
  logic [DATA_W-1:0] dat_w;  // Write data
  logic [SEL_W-1:0]  sel;    // Byte lane selects
  logic [DATA_W-1:0] dat_r;  // Read data, valid with ack
  logic              ack;    // One cycle acknowledge

  // Request side
  modport initiator (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack
  );

  // Response side
  modport target (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface

// ==== verilog/mem_tile.sv ====
// ************************************************
// Memory tile top
// Host port through the demux to L1 and the L2 bus
// ************************************************

`timescale 1ns/100ps

module mem_tile (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        tile_enable_i,

  // Host port
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [tile_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [tile_pkg::DATA_W-1:0] wb_dat_i,
  input  logic [tile_pkg::SEL_W-1:0]  wb_sel_i,
  output logic [tile_pkg::DATA_W-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,

  // External L2 port
  output logic                        l2_cyc_o,
  output logic                        l2_stb_o,
  output logic                        l2_we_o,
  output logic [tile_pkg::ADDR_W-1:0] l2_adr_o,
  output logic [tile_pkg::DATA_W-1:0] l2_dat_o,
  output logic [tile_pkg::SEL_W-1:0]  l2_sel_o,
  input  logic [tile_pkg::DATA_W-1:0] l2_dat_i,
  input  logic                        l2_ack_i
);

  mem_bus_if l1_bus ();   // Demux to scratchpad
  mem_bus_if l2_bus ();   // Demux to bridge

  tile_addr_demux i_demux (
    .clk_i,
    .rst_ni,
    .tile_enable_i,
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_sel_i,
    .wb_dat_o,
    .wb_ack_o,
    .wb_err_o,
    .l1_o          ( l1_bus ),
    .l2_o          ( l2_bus )
  );

  l1_spm i_l1_spm (
    .clk_i,
    .rst_ni,
    .bus_i  ( l1_bus )
  );

  l2_bridge i_l2_bridge (
    .clk_i,
    .rst_ni,
    .bus_i    ( l2_bus ),
    .l2_cyc_o,
    .l2_stb_o,
    .l2_we_o,
    .l2_adr_o,
    .l2_dat_o,
    .l2_sel_o,
    .l2_dat_i,
    .l2_ack_i
  );

endmodule

// ==== verilog/tile_addr_demux.sv ====
// ************************************************
// Tile address demux
// Registers the tile enable, decodes host accesses
// to L1 or L2 and answers unmapped ones with error
// ************************************************

`timescale 1ns/100ps

module tile_addr_demux (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        tile_enable_i,

  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [tile_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [tile_pkg::DATA_W-1:0] wb_dat_i,
  input  logic [tile_pkg::SEL_W-1:0]  wb_sel_i,
  output logic [tile_pkg::DATA_W-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,

  mem_bus_if.initiator                l1_o,
  mem_bus_if.initiator                l2_o
);
  import tile_pkg::*;

  logic     en_q;    // Registered tile enable
  logic     req;     // Host strobe while enabled
  logic     err_q;   // Error response flop
  tgt_sel_e tgt;

  always_ff @(posedge clk_i, negedge rst_ni) begin : enable_ff
    if (!rst_ni) en_q <= 1'b0;
    else         en_q <= tile_enable_i;
  end

  // Offset compare wraps below L1_BASE, so one compare covers the window
  always_comb begin : decode
    if ((wb_adr_i - L1_BASE) < ADDR_W'(N_BANKS * WORDS_PER_BANK * SEL_W)) begin
      tgt = TGT_L1;
    end else if ((wb_adr_i >= L2_BASE) && (wb_adr_i <= L2_END)) begin
      tgt = TGT_L2;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign req = wb_cyc_i & wb_stb_i & en_q;

  // Steering, only the selected target sees cyc and stb
  assign l1_o.cyc   = wb_cyc_i & en_q & (tgt == TGT_L1);
  assign l1_o.stb   = req & (tgt == TGT_L1);
  assign l1_o.we    = wb_we_i;
  assign l1_o.adr   = wb_adr_i;
  assign l1_o.dat_w = wb_dat_i;
  assign l1_o.sel   = wb_sel_i;

  assign l2_o.cyc   = wb_cyc_i & en_q & (tgt == TGT_L2);
  assign l2_o.stb   = req & (tgt == TGT_L2);
  assign l2_o.we    = wb_we_i;
  assign l2_o.adr   = wb_adr_i;
  assign l2_o.dat_w = wb_dat_i;
  assign l2_o.sel   = wb_sel_i;

  // Unmapped access, single cycle error one cycle after stb
  always_ff @(posedge clk_i, negedge rst_ni) begin : error_ff
    if (!rst_ni) err_q <= 1'b0;
    else         err_q <= req & (tgt == TGT_NONE) & ~err_q;   // No repeat while stb held
  end

  assign wb_err_o = err_q;

  // Response return from the decoded target
  always_comb begin : rsp_mux
    case (tgt)
      TGT_L1: begin
        wb_dat_o = l1_o.dat_r;
        wb_ack_o = l1_o.ack;
      end
      TGT_L2: begin
        wb_dat_o = l2_o.dat_r;
        wb_ack_o = l2_o.ack;
      end
      default: begin
        wb_dat_o = '0;
        wb_ack_o = 1'b0;   // Error path answers instead
      end
    endcase
  end

endmodule

// ==== verilog/tile_pkg.sv ====
// ************************************************
// Tile package
// Address map, bus widths and L1 bank geometry
// ************************************************

package tile_pkg;

  // Bus geometry
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned SEL_W  = DATA_W / 8;     // One select per byte lane

  // L1 scratchpad geometry
  localparam int unsigned N_BANKS        = 4;
  localparam int unsigned WORDS_PER_BANK = 64;
  localparam int unsigned BANK_IDX_W     = 2;      // Address bits 3:2
  localparam int unsigned ROW_IDX_W      = 6;      // Address bits 9:4

  // Address map
  localparam logic [ADDR_W-1:0] L1_BASE = 32'h1000_0000;   // 1 KiB window
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] L2_END  = 32'h8FFF_FFFF;   // Inclusive

  // Decode result of the address demux
  typedef enum logic [1:0] {
    TGT_L1   = 2'd0,
    TGT_L2   = 2'd1,
    TGT_NONE = 2'd2
  } tgt_sel_e;

endpackage
